//--- rv_decode_pkg.sv
package rv_decode_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_ARI_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_ARI_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_CSR       = 7'b1110011;
    localparam logic [6:0] OPC_FP_LOAD   = 7'b0000111;
    localparam logic [6:0] OPC_FP_STORE  = 7'b0100111;
    localparam logic [6:0] OPC_FP        = 7'b1010011;
    localparam logic [6:0] OPC_FP_MADD   = 7'b1000011;

    localparam logic [2:0] FNC_CSRRW = 3'b001;
    localparam logic [2:0] FNC_BEQ   = 3'b000;
    localparam logic [2:0] FNC_BNE   = 3'b001;
    localparam logic [2:0] FNC_BLT   = 3'b100;
    localparam logic [2:0] FNC_BGE   = 3'b101;
    localparam logic [2:0] FNC_BLTU  = 3'b110;
    localparam logic [2:0] FNC_BGEU  = 3'b111;

    // Float funct7, single precision only
    localparam logic [6:0] FNC7_FP_ADD     = 7'b0000000;
    localparam logic [6:0] FNC7_FP_FSGNJ_S = 7'b0010000;
    localparam logic [6:0] FNC7_FP_MV_X_W  = 7'b1110000;
    localparam logic [6:0] FNC7_FP_MV_W_X  = 7'b1111000;
    localparam logic [6:0] FNC7_FP_CVT_S_W = 7'b1101000;

    localparam logic [2:0] IMM_I    = 3'd0;
    localparam logic [2:0] IMM_S    = 3'd1;
    localparam logic [2:0] IMM_B    = 3'd2;
    localparam logic [2:0] IMM_U    = 3'd3;
    localparam logic [2:0] IMM_J    = 3'd4;
    localparam logic [2:0] IMM_NONE = 3'd7;

    localparam logic [1:0] TGT_BR   = 2'd0;
    localparam logic [1:0] TGT_JAL  = 2'd1;
    localparam logic [1:0] TGT_JALR = 2'd2;
    localparam logic [1:0] TGT_NONE = 2'd3;

    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_EX   = 2'd1;
    localparam logic [1:0] FWD_MEM  = 2'd2;
    localparam logic [1:0] FWD_WB   = 2'd3;

    // addi x0, x0, 0
    localparam logic [31:0] INST_NOP = 32'h0000_0013;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
        // Fused multiply-add, third source in the top bits
        struct packed {
            logic [4:0] rs3;
            logic [1:0] fmt;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] rm;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r4;
    } rv_inst_t;

endpackage

//--- pipe_tracker.sv
`timescale 1ns/1ps

module pipe_tracker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  logic [31:0]              fetch_inst,
    input  logic [31:0]              fetch_pc,
    output rv_decode_pkg::rv_inst_t id_inst,
    output rv_decode_pkg::rv_inst_t ex_inst,
    output rv_decode_pkg::rv_inst_t mem_inst,
    output rv_decode_pkg::rv_inst_t wb_inst,
    output logic [31:0]              id_pc
);

    import rv_decode_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_inst  <= INST_NOP;
            ex_inst  <= INST_NOP;
            mem_inst <= INST_NOP;
            wb_inst  <= INST_NOP;
            id_pc    <= '0;
        end else begin
            // ID holds on stall, the hazard drains as a bubble
            if (!stall) begin
                id_inst <= fetch_inst;
                id_pc   <= fetch_pc;
            end
            if (stall) begin
                ex_inst <= INST_NOP;
            end else begin
                ex_inst <= id_inst;
            end
            mem_inst <= ex_inst;
            wb_inst  <= mem_inst;
        end
    end

    a_bubble_after_stall: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> ex_inst == INST_NOP
    ) else $error("EX not a bubble after stall");

endmodule

//--- id_control.sv
`timescale 1ns/1ps

module id_control (
    input  rv_decode_pkg::rv_inst_t id_inst,
    input  rv_decode_pkg::rv_inst_t ex_inst,
    input  rv_decode_pkg::rv_inst_t mem_inst,
    input  rv_decode_pkg::rv_inst_t wb_inst,
    output logic [2:0]               imm_sel,
    output logic [1:0]               tgt_sel,
    output logic [1:0]               fwd_sel,
    output logic                     target_en,
    output logic                     stall
);

    import rv_decode_pkg::*;

    // Integer destination; FMV.X.W lands here, x0 never counts
    function automatic logic writes_rd(rv_inst_t inst);
        logic [6:0] op;
        op = inst.r.opcode;
        return !(op inside {OPC_STORE, OPC_BRANCH, OPC_CSR, OPC_FP_LOAD, OPC_FP_STORE,
                            OPC_FP_MADD})
            && (op != OPC_FP || inst.r.funct7 == FNC7_FP_MV_X_W)
            && inst.r.rd != 5'd0;
    endfunction

    function automatic logic writes_fd(rv_inst_t inst);
        return inst.r.opcode inside {OPC_FP_LOAD, OPC_FP_MADD}
            || (inst.r.opcode == OPC_FP && inst.r.funct7 != FNC7_FP_MV_X_W);
    endfunction

    logic [6:0] op;
    logic [6:0] funct7;
    logic [4:0] rs1, rs2, rs3, ex_rd;
    logic       has_rs1, has_rs2, has_fs1, has_fs2, has_fs3;
    logic       is_store, ex_load, ex_has_rd, ex_has_fd;
    logic       rs1_ex_hit, rs2_ex_hit, fs_ex_hit;

    assign op     = id_inst.r.opcode;
    assign funct7 = id_inst.r.funct7;
    assign rs1    = id_inst.r.rs1;
    assign rs2    = id_inst.r.rs2;
    assign rs3    = id_inst.r4.rs3;
    assign ex_rd  = ex_inst.r.rd;

    assign has_rs1 = rs1 != 5'd0
        && !(op inside {OPC_AUIPC, OPC_LUI, OPC_JAL, OPC_FP_MADD})
        && (op != OPC_CSR || id_inst.r.funct3 == FNC_CSRRW)
        && (op != OPC_FP || funct7 inside {FNC7_FP_MV_W_X, FNC7_FP_CVT_S_W});
    assign has_rs2 = rs2 != 5'd0 && op inside {OPC_ARI_RTYPE, OPC_STORE, OPC_BRANCH};
    assign has_fs1 = op == OPC_FP_MADD
        || (op == OPC_FP && funct7 inside {FNC7_FP_MV_X_W, FNC7_FP_FSGNJ_S, FNC7_FP_ADD});
    assign has_fs2 = op inside {OPC_FP_STORE, OPC_FP_MADD}
        || (op == OPC_FP && funct7 inside {FNC7_FP_FSGNJ_S, FNC7_FP_ADD});
    assign has_fs3 = op == OPC_FP_MADD;

    assign is_store  = op inside {OPC_STORE, OPC_FP_STORE};
    assign ex_load   = ex_inst.r.opcode inside {OPC_LOAD, OPC_FP_LOAD};
    assign ex_has_rd = writes_rd(ex_inst);
    assign ex_has_fd = writes_fd(ex_inst);

    assign rs1_ex_hit = has_rs1 && ex_has_rd && rs1 == ex_rd;
    assign rs2_ex_hit = has_rs2 && ex_has_rd && rs2 == ex_rd;
    assign fs_ex_hit  = ex_has_fd && ((has_fs1 && rs1 == ex_rd) || (has_fs2 && rs2 == ex_rd)
                                      || (has_fs3 && rs3 == ex_rd));

    // Store data is picked up later, only its address blocks
    assign stall = ex_load && (rs1_ex_hit || (!is_store && (rs2_ex_hit || fs_ex_hit)));

    always_comb begin
        fwd_sel = FWD_NONE;
        if (rs1_ex_hit) begin
            fwd_sel = FWD_EX;
        end else if (has_rs1 && writes_rd(mem_inst) && rs1 == mem_inst.r.rd) begin
            fwd_sel = FWD_MEM;
        end else if (has_rs1 && writes_rd(wb_inst) && rs1 == wb_inst.r.rd) begin
            fwd_sel = FWD_WB;
        end
    end

    always_comb begin
        imm_sel   = IMM_NONE;
        tgt_sel   = TGT_NONE;
        target_en = 1'b0;
        case (op)
            OPC_ARI_ITYPE, OPC_LOAD, OPC_FP_LOAD: imm_sel = IMM_I;
            OPC_STORE, OPC_FP_STORE: imm_sel = IMM_S;
            OPC_LUI, OPC_AUIPC: imm_sel = IMM_U;
            OPC_BRANCH: begin
                imm_sel   = IMM_B;
                tgt_sel   = TGT_BR;
                target_en = id_inst.b.funct3 inside {FNC_BEQ, FNC_BNE, FNC_BLT, FNC_BGE,
                                                     FNC_BLTU, FNC_BGEU};
            end
            OPC_JAL: begin
                imm_sel   = IMM_J;
                tgt_sel   = TGT_JAL;
                target_en = 1'b1;
            end
            OPC_JALR: begin
                imm_sel   = IMM_I;
                tgt_sel   = TGT_JALR;
                // Base still in flight from the load
                target_en = !(ex_load && rs1_ex_hit);
            end
            default: ;
        endcase
    end

    a_stall_on_load: assert final (!stall || ex_inst.i.opcode inside {OPC_LOAD, OPC_FP_LOAD})
        else $error("Stall without a load in EX");

endmodule

//--- imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::rv_inst_t id_inst,
    input  logic [2:0]               imm_sel,
    output logic [31:0]              imm
);

    import rv_decode_pkg::*;

    always_comb begin
        case (imm_sel)
            IMM_I: imm = {{20{id_inst.i.imm_11_0[11]}}, id_inst.i.imm_11_0};
            IMM_S: imm = {{20{id_inst.s.imm_11_5[6]}}, id_inst.s.imm_11_5, id_inst.s.imm_4_0};
            IMM_B: begin
                imm = {{19{id_inst.b.imm_12}}, id_inst.b.imm_12, id_inst.b.imm_11,
                       id_inst.b.imm_10_5, id_inst.b.imm_4_1, 1'b0};
            end
            IMM_U: imm = {id_inst.u.imm_31_12, 12'b0};
            IMM_J: begin
                imm = {{11{id_inst.j.imm_20}}, id_inst.j.imm_20, id_inst.j.imm_19_12,
                       id_inst.j.imm_11, id_inst.j.imm_10_1, 1'b0};
            end
            // IMM_NONE
            default: imm = '0;
        endcase
    end

endmodule

//--- target_gen.sv
`timescale 1ns/1ps

module target_gen (
    input  logic [31:0] id_pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] ex_result,
    input  logic [31:0] mem_result,
    input  logic [31:0] wb_result,
    input  logic [31:0] imm,
    input  logic [1:0]  tgt_sel,
    input  logic [1:0]  fwd_sel,
    input  logic        target_en,
    output logic        target_valid,
    output logic [31:0] target
);

    import rv_decode_pkg::*;

    logic [31:0] rs1_fwd;
    logic [31:0] jalr_sum;

    always_comb begin
        case (fwd_sel)
            FWD_EX:  rs1_fwd = ex_result;
            FWD_MEM: rs1_fwd = mem_result;
            FWD_WB:  rs1_fwd = wb_result;
            default: rs1_fwd = rs1_data;
        endcase
    end

    assign jalr_sum = rs1_fwd + imm;

    always_comb begin
        case (tgt_sel)
            TGT_BR, TGT_JAL: target = id_pc + imm;
            TGT_JALR:        target = {jalr_sum[31:1], 1'b0};
            default:         target = '0;
        endcase
    end

    assign target_valid = target_en;

    a_target_aligned: assert final (!target_valid || !target[0])
        else $error("Odd target 0x%08h", target);

endmodule

//--- id_perf_regs.sv
`timescale 1ns/1ps

module id_perf_regs #(
    parameter int CNT_WIDTH = 16
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        target_valid,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    logic [CNT_WIDTH-1:0] stall_cnt;
    logic [CNT_WIDTH-1:0] redirect_cnt;
    logic                 wb_req;
    logic                 clear;

    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    // Master still holds the write during ack
    assign clear  = wb_ack && wb_cyc && wb_stb && wb_we && wb_adr == 4'd8 && wb_dat_w[0];

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            stall_cnt    <= '0;
            redirect_cnt <= '0;
        end else begin
            if (stall && stall_cnt != '1) begin
                stall_cnt <= stall_cnt + 1'b1;
            end
            if (target_valid && !stall && redirect_cnt != '1) begin
                redirect_cnt <= redirect_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            case (wb_adr)
                4'd0:    wb_dat_r <= 32'(stall_cnt);
                4'd4:    wb_dat_r <= 32'(redirect_cnt);
                default: wb_dat_r <= '0;
            endcase
        end
    end

    a_ack_follows_req: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb)
    ) else $error("wb_ack without a request");

endmodule

//--- id_stage_top.sv
`timescale 1ns/1ps

module id_stage_top #(
    parameter int CNT_WIDTH = 16
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] fetch_inst,
    input  logic [31:0] fetch_pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] ex_result,
    input  logic [31:0] mem_result,
    input  logic [31:0] wb_result,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic        stall,
    output logic [31:0] imm,
    output logic        target_valid,
    output logic [31:0] target,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    import rv_decode_pkg::*;

    rv_inst_t    id_inst, ex_inst, mem_inst, wb_inst;
    logic [31:0] id_pc;
    logic [2:0]  imm_sel;
    logic [1:0]  tgt_sel;
    logic [1:0]  fwd_sel;
    logic        target_en;

    pipe_tracker u_pipe_tracker (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .fetch_inst (fetch_inst),
        .fetch_pc   (fetch_pc),
        .id_inst    (id_inst),
        .ex_inst    (ex_inst),
        .mem_inst   (mem_inst),
        .wb_inst    (wb_inst),
        .id_pc      (id_pc)
    );

    id_control u_id_control (
        .id_inst   (id_inst),
        .ex_inst   (ex_inst),
        .mem_inst  (mem_inst),
        .wb_inst   (wb_inst),
        .imm_sel   (imm_sel),
        .tgt_sel   (tgt_sel),
        .fwd_sel   (fwd_sel),
        .target_en (target_en),
        .stall     (stall)
    );

    imm_gen u_imm_gen (
        .id_inst (id_inst),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    target_gen u_target_gen (
        .id_pc        (id_pc),
        .rs1_data     (rs1_data),
        .ex_result    (ex_result),
        .mem_result   (mem_result),
        .wb_result    (wb_result),
        .imm          (imm),
        .tgt_sel      (tgt_sel),
        .fwd_sel      (fwd_sel),
        .target_en    (target_en),
        .target_valid (target_valid),
        .target       (target)
    );

    id_perf_regs #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_id_perf_regs (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .target_valid (target_valid),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

endmodule

//--- tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

    import rv_decode_pkg::*;

    localparam int WB_ACCESSES = 5;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rs1d;
        logic [31:0] exr;
        logic [31:0] memr;
        logic [31:0] wbr;
        logic        exp_stall;
        logic [31:0] exp_imm;
        logic        exp_tv;
        logic [31:0] exp_tgt;
        logic        exp_tv2;
    } row_t;

    logic        clk;
    logic        reset;
    logic [31:0] fetch_inst, fetch_pc, rs1_data;
    logic [31:0] ex_result, mem_result, wb_result;
    logic        wb_cyc, wb_stb, wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic        stall, target_valid, wb_ack;
    logic [31:0] imm, target, wb_dat_r;

    row_t        rows [0:63];
    int          n_rows = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;
    logic [31:0] lcg_state = 32'd41015;

    id_stage_top #(
        .CNT_WIDTH (16)
    ) dut (
        .clk          (clk),
        .reset        (reset),
        .fetch_inst   (fetch_inst),
        .fetch_pc     (fetch_pc),
        .rs1_data     (rs1_data),
        .ex_result    (ex_result),
        .mem_result   (mem_result),
        .wb_result    (wb_result),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .stall        (stall),
        .imm          (imm),
        .target_valid (target_valid),
        .target       (target),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, DUT stopped making progress", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Instruction encoders from the ISA formats
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] im, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {im, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] im, logic [4:0] rs2, logic [4:0] rs1);
        return {im[11:5], rs2, rs1, 3'b010, im[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] im, logic [4:0] rs2, logic [4:0] rs1);
        return {im[12], im[10:5], rs2, rs1, FNC_BEQ, im[4:1], im[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] im, logic [4:0] rd);
        return {im[20], im[10:1], im[11], im[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] cur_pc();
        return 32'h100 + 32'(4 * n_rows);
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic [31:0] rs1d,
                           input logic [31:0] exr, input logic [31:0] memr,
                           input logic [31:0] wbr, input logic st, input logic [31:0] im,
                           input logic tv, input logic [31:0] tgt, input logic tv2);
        row_t r;
        r = {inst, cur_pc(), rs1d, exr, memr, wbr, st, im, tv, tgt, tv2};
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic add_fixed(input logic [31:0] inst, input logic st, input logic [31:0] im,
                             input logic tv, input logic [31:0] tgt, input logic tv2);
        add_row(inst, 32'h4000, 32'h1000, 32'h2000, 32'h3000, st, im, tv, tgt, tv2);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic end_test(input string what);
        if (errors == err_mark) begin
            n_pass++;
            $display("%s : ok", what);
        end else begin
            n_fail++;
            $display("%s : failed", what);
        end
        err_mark = errors;
    endtask

    task automatic build_table();
        logic [31:0] r, rs1d, exr, memr, wbr, base;
        logic [4:0]  rd [3];
        logic [4:0]  rs1;
        logic [11:0] im;
        // Immediates per format
        add_fixed(enc_i(12'hFFB, 0, 3'b000, 1, OPC_ARI_ITYPE), 0, 32'hFFFF_FFFB, 0, 0, 0);
        add_fixed(enc_s(12'hFF8, 2, 3), 0, 32'hFFFF_FFF8, 0, 0, 0);
        add_fixed(enc_b(13'h1FF0, 2, 1), 0, 32'hFFFF_FFF0, 1, cur_pc() - 32'd16, 0);
        add_fixed({20'hABCDE, 5'd4, OPC_LUI}, 0, 32'hABCD_E000, 0, 0, 0);
        add_fixed(enc_j(21'h07F7FE, 1), 0, 32'h0007_F7FE, 1, cur_pc() + 32'h7F7FE, 0);
        add_fixed(enc_r(0, 2, 1, 0, 6, OPC_ARI_RTYPE), 0, 0, 0, 0, 0);
        // Load-use
        add_fixed(enc_i(0, 1, 3'b010, 5, OPC_LOAD), 0, 0, 0, 0, 0);
        add_fixed(enc_r(0, 3, 5, 0, 7, OPC_ARI_RTYPE), 1, 0, 0, 0, 0);
        add_fixed(enc_i(12'h00C, 1, 3'b010, 5, OPC_LOAD), 0, 32'hC, 0, 0, 0);
        add_fixed(enc_s(12'h004, 5, 2), 0, 32'd4, 0, 0, 0);
        add_fixed(enc_i(0, 1, 3'b010, 0, OPC_LOAD), 0, 0, 0, 0, 0);
        add_fixed(enc_r(0, 0, 0, 0, 8, OPC_ARI_RTYPE), 0, 0, 0, 0, 0);
        // JALR forwarding with x12 written twice so EX must win
        add_fixed(enc_i(12'h001, 0, 0, 10, OPC_ARI_ITYPE), 0, 32'd1, 0, 0, 0);
        add_fixed(enc_i(12'h002, 0, 0, 12, OPC_ARI_ITYPE), 0, 32'd2, 0, 0, 0);
        add_fixed(enc_i(12'h003, 0, 0, 12, OPC_ARI_ITYPE), 0, 32'd3, 0, 0, 0);
        add_fixed(enc_i(12'h021, 12, 0, 0, OPC_JALR), 0, 32'h21, 1, 32'h1020, 0);
        add_fixed(enc_i(12'h011, 12, 0, 0, OPC_JALR), 0, 32'h11, 1, 32'h2010, 0);
        add_fixed(enc_i(12'hFFE, 12, 0, 0, OPC_JALR), 0, 32'hFFFF_FFFE, 1, 32'h2FFE, 0);
        add_fixed(enc_i(12'h007, 13, 0, 0, OPC_JALR), 0, 32'h7, 1, 32'h4006, 0);
        add_fixed(enc_i(0, 1, 3'b010, 14, OPC_LOAD), 0, 0, 0, 0, 0);
        add_fixed(enc_i(12'h008, 14, 0, 0, OPC_JALR), 1, 32'h8, 0, 0, 1);
        // Float hazards
        add_fixed(enc_i(0, 1, 3'b010, 3, OPC_FP_LOAD), 0, 0, 0, 0, 0);
        add_fixed(enc_r(FNC7_FP_ADD, 1, 3, 0, 4, OPC_FP), 1, 0, 0, 0, 0);
        add_fixed(enc_r(FNC7_FP_MV_X_W, 0, 2, 0, 9, OPC_FP), 0, 0, 0, 0, 0);
        add_fixed(enc_i(12'h004, 9, 0, 0, OPC_JALR), 0, 32'h4, 1, 32'h1004, 0);
        // Random groups of three ADDIs then a JALR
        for (int g = 0; g < 4; g++) begin
            for (int k = 0; k < 3; k++) begin
                r = next_rand();
                rd[k] = {2'b00, r[18:16]};
                im = r[27:16];
                add_row(enc_i(im, 0, 0, rd[k], OPC_ARI_ITYPE), r, r, r, r, 0, sext12(im),
                        0, 0, 0);
            end
            r = next_rand();
            rs1 = {2'b00, r[18:16]};
            im = r[27:16];
            rs1d = next_rand();
            exr = next_rand();
            memr = next_rand();
            wbr = next_rand();
            // Youngest writer wins and x0 is never forwarded
            if (rs1 == 5'd0) base = rs1d;
            else if (rs1 == rd[2]) base = exr;
            else if (rs1 == rd[1]) base = memr;
            else if (rs1 == rd[0]) base = wbr;
            else base = rs1d;
            add_row(enc_i(im, rs1, 0, 0, OPC_JALR), rs1d, exr, memr, wbr, 0, sext12(im), 1,
                    (base + sext12(im)) & ~32'h1, 0);
        end
    endtask

    task automatic drive_row(input int idx);
        fetch_inst = rows[idx].inst;
        fetch_pc   = rows[idx].pc;
        rs1_data   = rows[idx].rs1d;
        ex_result  = rows[idx].exr;
        mem_result = rows[idx].memr;
        wb_result  = rows[idx].wbr;
    endtask

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge clk);
        // Ack one clock after the request
        check_val("wb_ack", wb_ack, 32'd1);
        while (!wb_ack) @(negedge clk);
        rdata = wb_dat_r;
        // Hold through the end of the ack cycle
        @(negedge clk);
        check_val("wb_ack", wb_ack, 32'd0);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    initial begin
        int          held;
        int          exp_stalls;
        int          exp_redirects;
        logic [31:0] rdata;
        exp_stalls = 0;
        exp_redirects = 0;
        reset = 1'b1;
        fetch_inst = INST_NOP;
        fetch_pc = '0;
        rs1_data = '0;
        ex_result = '0;
        mem_result = '0;
        wb_result = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        build_table();
        cycle_limit = 2 * (n_rows + WB_ACCESSES) + 50;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        drive_row(0);
        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            check_val("stall", stall, rows[i].exp_stall);
            check_val("imm", imm, rows[i].exp_imm);
            check_val("target_valid", target_valid, rows[i].exp_tv);
            if (rows[i].exp_tv) check_val("target", target, rows[i].exp_tgt);
            if (i + 1 < n_rows) drive_row(i + 1);
            else fetch_inst = INST_NOP;
            held = 0;
            while (stall) begin
                @(negedge clk);
                held++;
            end
            if (rows[i].exp_stall) begin
                assert (held == 1) else begin
                    $display("Row %0d stall lasted %0d cycles instead of one", i, held);
                    errors++;
                end
                check_val("imm", imm, rows[i].exp_imm);
                check_val("target_valid", target_valid, rows[i].exp_tv2);
            end
            exp_stalls += rows[i].exp_stall;
            exp_redirects += rows[i].exp_stall ? rows[i].exp_tv2 : rows[i].exp_tv;
            end_test($sformatf("row %0d inst 0x%08h", i, rows[i].inst));
        end
        // Let the last row leave ID before reading counters
        repeat (3) @(negedge clk);
        wb_access(1'b0, 4'd0, '0, rdata);
        check_val("wb_dat_r", rdata, 32'(exp_stalls));
        end_test("stall count read");
        wb_access(1'b0, 4'd4, '0, rdata);
        check_val("wb_dat_r", rdata, 32'(exp_redirects));
        end_test("redirect count read");
        wb_access(1'b1, 4'd8, 32'd1, rdata);
        end_test("counter clear write");
        wb_access(1'b0, 4'd0, '0, rdata);
        check_val("wb_dat_r", rdata, 32'd0);
        end_test("stall count after clear");
        wb_access(1'b0, 4'd4, '0, rdata);
        check_val("wb_dat_r", rdata, 32'd0);
        end_test("redirect count after clear");
        $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
rv_decode_pkg.sv
pipe_tracker.sv
id_control.sv
imm_gen.sv
target_gen.sv
id_perf_regs.sv
id_stage_top.sv
tb_id_stage.sv

//--- Bender.yml
package:
  name: rv_id_stage

sources:
  - files:
      - rv_decode_pkg.sv
      - pipe_tracker.sv
      - id_control.sv
      - imm_gen.sv
      - target_gen.sv
      - id_perf_regs.sv
      - id_stage_top.sv
  - target: simulation
    files:
      - tb_id_stage.sv
